// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tbCore
RTL_TOP  := rvCore
FILELIST := list.f
BUILD    := obj_dir
LOG      := sim.log

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter design/%,$(SRCS))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD) $(LOG)

// File: design/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore #(
   parameter int NumRegs = 32
) (
   input  wire logic          clk,
   input  wire logic          rstn,
   input  wire logic          start,
   input  wire logic          memAck,
   input  wire rvPkg::wordT   memRdata,
   output      logic          memReqValid,
   output      rvPkg::memReqT memReq,
   output      logic          halted
);

   rvPkg::wordT    inst;
   rvPkg::decodedT dec;
   rvPkg::wordT    aluResult;
   rvPkg::wordT    rs1Data;
   rvPkg::wordT    rs2Data;
   logic           regWe;
   rvPkg::regIdxT  regWaddr;
   rvPkg::wordT    regWdata;

   rvSequencer uSeq (
      .clk         (clk),
      .rstn        (rstn),
      .start       (start),
      .memAck      (memAck),
      .memRdata    (memRdata),
      .memReqValid (memReqValid),
      .memReq      (memReq),
      .inst        (inst),
      .dec         (dec),
      .aluResult   (aluResult),
      .rs2Data     (rs2Data),
      .regWe       (regWe),
      .regWaddr    (regWaddr),
      .regWdata    (regWdata),
      .halted      (halted)
   );

   rvDecoder uDec (
      .inst (inst),
      .dec  (dec)
   );

   rvExecute uExe (
      .dec       (dec),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data),
      .aluResult (aluResult)
   );

   rvRegFile #(.NumRegs(NumRegs)) uRf (
      .clk     (clk),
      .rstn    (rstn),
      .rs1     (dec.rs1),
      .rs2     (dec.rs2),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data),
      .we      (regWe),
      .waddr   (regWaddr),
      .wdata   (regWdata)
   );

endmodule

`default_nettype wire

// File: design/rvDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module rvDecoder (
   input  wire rvPkg::wordT    inst,
   output      rvPkg::decodedT dec
);

   localparam int SignW = rvPkg::XLEN - 12;

   rvPkg::opcodeT opcode;
   logic [2:0]    funct3;
   logic [6:0]    funct7;
   rvPkg::wordT   immI;
   rvPkg::wordT   immS;
   rvPkg::wordT   immU;
   rvPkg::wordT   shamt;

   assign opcode = inst[6:0];
   assign funct3 = inst[14:12];
   assign funct7 = inst[31:25];

   assign immI  = {{SignW{inst[31]}}, inst[31:20]};
   assign immS  = {{SignW{inst[31]}}, inst[31:25], inst[11:7]};
   assign immU  = {inst[31:12], 12'b0};
   assign shamt = {{(rvPkg::XLEN-5){1'b0}}, inst[24:20]};

   always_comb begin
      dec.cls    = rvPkg::CLS_ILLEGAL;
      dec.aluOp  = rvPkg::ALU_ADD;
      dec.rs1    = inst[19:15];
      dec.rs2    = inst[24:20];
      dec.rd     = inst[11:7];
      dec.imm    = immI;
      dec.useImm = 1'b1;
      case (opcode)
         rvPkg::OPC_LUI: begin
            dec.cls   = rvPkg::CLS_ALU;
            dec.aluOp = rvPkg::ALU_LUI;
            dec.imm   = immU;
         end
         rvPkg::OPC_OPIMM: begin
            dec.cls = rvPkg::CLS_ALU;
            case (funct3)
               3'b000: dec.aluOp = rvPkg::ALU_ADD;
               3'b010: dec.aluOp = rvPkg::ALU_SLT;
               3'b011: dec.aluOp = rvPkg::ALU_SLTU;   // imm still sign extended
               3'b100: dec.aluOp = rvPkg::ALU_XOR;
               3'b110: dec.aluOp = rvPkg::ALU_OR;
               3'b111: dec.aluOp = rvPkg::ALU_AND;
               default: begin
                  // shifts need an exact funct7
                  dec.imm = shamt;
                  if (funct3 == 3'b001 && funct7 == 7'b0000000) dec.aluOp = rvPkg::ALU_SLL;
                  else if (funct7 == 7'b0000000) dec.aluOp = rvPkg::ALU_SRL;
                  else if (funct7 == 7'b0100000 && funct3 == 3'b101) dec.aluOp = rvPkg::ALU_SRA;
                  else dec.cls = rvPkg::CLS_ILLEGAL;
               end
            endcase
         end
         rvPkg::OPC_OP: begin
            dec.cls    = rvPkg::CLS_ALU;
            dec.useImm = 1'b0;
            case ({funct7, funct3})
               {7'b0000000, 3'b000}: dec.aluOp = rvPkg::ALU_ADD;
               {7'b0100000, 3'b000}: dec.aluOp = rvPkg::ALU_SUB;
               {7'b0000000, 3'b001}: dec.aluOp = rvPkg::ALU_SLL;
               {7'b0000000, 3'b010}: dec.aluOp = rvPkg::ALU_SLT;
               {7'b0000000, 3'b011}: dec.aluOp = rvPkg::ALU_SLTU;
               {7'b0000000, 3'b100}: dec.aluOp = rvPkg::ALU_XOR;
               {7'b0000000, 3'b110}: dec.aluOp = rvPkg::ALU_OR;
               {7'b0000000, 3'b111}: dec.aluOp = rvPkg::ALU_AND;
               default:              dec.cls   = rvPkg::CLS_ILLEGAL;
            endcase
         end
         rvPkg::OPC_LOAD: begin
            if (funct3 == 3'b010) dec.cls = rvPkg::CLS_LOAD;   // LW only
         end
         rvPkg::OPC_STORE: begin
            dec.imm = immS;
            if (funct3 == 3'b010) dec.cls = rvPkg::CLS_STORE;
         end
         rvPkg::OPC_HALT: dec.cls = rvPkg::CLS_HALT;
         default:         dec.cls = rvPkg::CLS_ILLEGAL;
      endcase
   end

endmodule

`default_nettype wire

// File: design/rvExecute.sv
`timescale 1ns/1ps
`default_nettype none

module rvExecute (
   input  wire rvPkg::decodedT dec,
   input  wire rvPkg::wordT    rs1Data,
   input  wire rvPkg::wordT    rs2Data,
   output      rvPkg::wordT    aluResult
);

   rvPkg::wordT opB;
   logic [4:0]  shamt;
   logic        ltSigned;
   logic        ltUnsigned;

   assign opB        = dec.useImm ? dec.imm : rs2Data;
   assign shamt      = opB[4:0];   // only the low bits count
   assign ltSigned   = $signed(rs1Data) < $signed(opB);
   assign ltUnsigned = rs1Data < opB;

   // loads and stores come through ALU_ADD with the immediate, giving the address
   always_comb begin
      case (dec.aluOp)
         rvPkg::ALU_ADD:  aluResult = rs1Data + opB;
         rvPkg::ALU_SUB:  aluResult = rs1Data - opB;
         rvPkg::ALU_SLL:  aluResult = rs1Data << shamt;
         rvPkg::ALU_SLT:  aluResult = {{(rvPkg::XLEN-1){1'b0}}, ltSigned};
         rvPkg::ALU_SLTU: aluResult = {{(rvPkg::XLEN-1){1'b0}}, ltUnsigned};
         rvPkg::ALU_XOR:  aluResult = rs1Data ^ opB;
         rvPkg::ALU_SRL:  aluResult = rs1Data >> shamt;
         rvPkg::ALU_SRA:  aluResult = rvPkg::wordT'($signed(rs1Data) >>> shamt);
         rvPkg::ALU_OR:   aluResult = rs1Data | opB;
         rvPkg::ALU_AND:  aluResult = rs1Data & opB;
         rvPkg::ALU_LUI:  aluResult = dec.imm;
         default:         aluResult = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: design/rvPkg.sv
`default_nettype none

package rvPkg;

   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] wordT;   // data, word addresses, instructions
   typedef logic [4:0]      regIdxT;
   typedef logic [6:0]      opcodeT;

   localparam opcodeT OPC_LUI   = 7'b0110111;
   localparam opcodeT OPC_OPIMM = 7'b0010011;
   localparam opcodeT OPC_OP    = 7'b0110011;
   localparam opcodeT OPC_LOAD  = 7'b0000011;
   localparam opcodeT OPC_STORE = 7'b0100011;
   localparam opcodeT OPC_HALT  = 7'h7F;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND,
      ALU_LUI   // passes the immediate
   } aluOpT;

   typedef enum logic [2:0] {
      CLS_ALU,
      CLS_LOAD,
      CLS_STORE,
      CLS_HALT,
      CLS_ILLEGAL
   } instClassT;

   typedef struct packed {
      instClassT cls;
      aluOpT     aluOp;
      regIdxT    rs1;
      regIdxT    rs2;
      regIdxT    rd;
      wordT      imm;      // already extended
      logic      useImm;   // immediate replaces rs2 as operand b
   } decodedT;

   typedef struct packed {
      wordT addr;
      wordT wdata;
      logic we;
   } memReqT;

   typedef enum logic [1:0] {
      ST_HALT,
      ST_FETCH,
      ST_EXEC,
      ST_MEM
   } seqStateT;

endpackage

`default_nettype wire

// File: design/rvRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module rvRegFile #(
   parameter int NumRegs = 32
) (
   input  wire logic          clk,
   input  wire logic          rstn,
   input  wire rvPkg::regIdxT rs1,
   input  wire rvPkg::regIdxT rs2,
   output      rvPkg::wordT   rs1Data,
   output      rvPkg::wordT   rs2Data,
   input  wire logic          we,
   input  wire rvPkg::regIdxT waddr,
   input  wire rvPkg::wordT   wdata
);

   localparam int IdxW = $clog2(NumRegs);

   rvPkg::wordT regs [NumRegs];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < NumRegs; i++) regs[i] <= '0;
      end else if (we && waddr != '0 && int'(waddr) < NumRegs) begin
         regs[waddr[IdxW-1:0]] <= wdata;
      end
   end

   // x0 and indices beyond NumRegs read as zero
   assign rs1Data = (rs1 == '0 || int'(rs1) >= NumRegs) ? '0 : regs[rs1[IdxW-1:0]];
   assign rs2Data = (rs2 == '0 || int'(rs2) >= NumRegs) ? '0 : regs[rs2[IdxW-1:0]];

   assert property (@(posedge clk) disable iff (!rstn) regs[0] == '0);

endmodule

`default_nettype wire

// File: design/rvSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module rvSequencer (
   input  wire logic           clk,
   input  wire logic           rstn,
   input  wire logic           start,
   input  wire logic           memAck,
   input  wire rvPkg::wordT    memRdata,
   output      logic           memReqValid,
   output      rvPkg::memReqT  memReq,
   output      rvPkg::wordT    inst,
   input  wire rvPkg::decodedT dec,
   input  wire rvPkg::wordT    aluResult,
   input  wire rvPkg::wordT    rs2Data,
   output      logic           regWe,
   output      rvPkg::regIdxT  regWaddr,
   output      rvPkg::wordT    regWdata,
   output      logic           halted
);

   rvPkg::seqStateT state;
   rvPkg::wordT     pc;
   logic            isMemOp;
   logic            issueFetch;
   logic            issueMem;

   assign isMemOp = (dec.cls == rvPkg::CLS_LOAD) || (dec.cls == rvPkg::CLS_STORE);

   // a new fetch starts after start, after an ALU op, or right after a data access
   assign issueFetch = (state == rvPkg::ST_HALT && start) ||
                       (state == rvPkg::ST_EXEC && dec.cls == rvPkg::CLS_ALU) ||
                       (state == rvPkg::ST_MEM && memAck);
   assign issueMem   = (state == rvPkg::ST_EXEC) && isMemOp;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state       <= rvPkg::ST_HALT;
         pc          <= '0;
         memReqValid <= 1'b0;
      end else begin
         // held until acked, then dropped unless the next one follows
         memReqValid <= issueFetch || issueMem || (memReqValid && !memAck);
         case (state)
            rvPkg::ST_HALT: begin
               if (start) state <= rvPkg::ST_FETCH;
            end
            rvPkg::ST_FETCH: begin
               if (memAck) begin
                  state <= rvPkg::ST_EXEC;
                  pc    <= pc + 1'b1;   // word addressed
               end
            end
            rvPkg::ST_EXEC: begin
               case (dec.cls)
                  rvPkg::CLS_ALU:   state <= rvPkg::ST_FETCH;
                  rvPkg::CLS_LOAD,
                  rvPkg::CLS_STORE: state <= rvPkg::ST_MEM;
                  default:          state <= rvPkg::ST_HALT;   // halt or illegal
               endcase
            end
            rvPkg::ST_MEM: begin
               if (memAck) state <= rvPkg::ST_FETCH;
            end
            default: state <= rvPkg::ST_HALT;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == rvPkg::ST_FETCH && memAck) inst <= memRdata;
      if (issueFetch) begin
         memReq.addr  <= pc;
         memReq.wdata <= '0;
         memReq.we    <= 1'b0;
      end else if (issueMem) begin
         memReq.addr  <= aluResult;
         memReq.wdata <= rs2Data;
         memReq.we    <= (dec.cls == rvPkg::CLS_STORE);
      end
   end

   // ALU result written at the end of exec, load data in the ack cycle
   assign regWe    = (state == rvPkg::ST_EXEC && dec.cls == rvPkg::CLS_ALU) ||
                     (state == rvPkg::ST_MEM && memAck && !memReq.we);
   assign regWaddr = dec.rd;
   assign regWdata = (state == rvPkg::ST_MEM) ? memRdata : aluResult;
   assign halted   = (state == rvPkg::ST_HALT);

   assert property (@(posedge clk) disable iff (!rstn)
      memReqValid && !memAck |=> memReqValid && $stable(memReq));

   assert property (@(posedge clk) disable iff (!rstn)
      state == rvPkg::ST_HALT |-> !regWe);

endmodule

`default_nettype wire

// File: dv/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
   parameter int HalfPeriodNs = 2,
   parameter int ResetCycles  = 8
) (
   input  wire logic resetReq,
   output      logic clk,
   output      logic rstn
);

   int   holdCount;
   logic reqSeen;

   initial begin
      clk       = 1'b0;
      rstn      = 1'b0;
      holdCount = ResetCycles;   // power-up reset
   end

   always #(HalfPeriodNs) clk = ~clk;

   // rstn low for ResetCycles rising edges after power-up or a request
   always @(posedge clk) begin
      reqSeen = resetReq;
      #1;
      if (reqSeen) holdCount = ResetCycles;
      else if (holdCount > 0) holdCount = holdCount - 1;
      rstn = (holdCount == 0);
   end

endmodule

`default_nettype wire

// File: dv/tbCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbCore;

   localparam int MemWords  = 256;
   localparam int MaxCycles = 4000;   // ~120 accesses x 5 cycles x 6
   localparam logic [6:0]  OpLui    = 7'b0110111;
   localparam logic [6:0]  OpImm    = 7'b0010011;
   localparam logic [6:0]  OpReg    = 7'b0110011;
   localparam logic [6:0]  OpLoad   = 7'b0000011;
   localparam logic [6:0]  OpStore  = 7'b0100011;
   localparam logic [31:0] HaltWord = 32'h0000_007F;
   localparam logic [2:0]  RegF3 [8] = '{3'b000, 3'b000, 3'b001, 3'b010,
                                         3'b011, 3'b100, 3'b110, 3'b111};

   logic          clk;
   logic          rstn;
   logic          resetReq;
   logic          start;
   logic          memAck;
   rvPkg::wordT   memRdata;
   logic          memReqValid;
   rvPkg::memReqT memReq;
   logic          halted;

   logic [31:0] mem [MemWords];
   logic [31:0] prog [$];
   logic [31:0] reqAddrs [$];   // every acknowledged request in order
   logic [31:0] rngState;
   int          maxDelay;
   int          cycles;
   int          writeCount;

   tbClock clkGen (.resetReq(resetReq), .clk(clk), .rstn(rstn));

   rvCore UUT (
      .clk(clk), .rstn(rstn), .start(start), .memAck(memAck), .memRdata(memRdata),
      .memReqValid(memReqValid), .memReq(memReq), .halted(halted)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] fillWord(input int addr);
      return 32'hEE00_0000 | 32'(addr);
   endfunction

   function automatic logic [31:0] lui(input int rd, input logic [19:0] imm20);
      return {imm20, rd[4:0], OpLui};
   endfunction

   function automatic logic [31:0] opImm(input logic [2:0] f3, input int rd, input int rs1,
                                         input int imm);
      return {imm[11:0], rs1[4:0], f3, rd[4:0], OpImm};
   endfunction

   function automatic logic [31:0] opReg(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
      return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OpReg};
   endfunction

   function automatic logic [31:0] lw(input int rd, input int rs1, input int off);
      return {off[11:0], rs1[4:0], 3'b010, rd[4:0], OpLoad};
   endfunction

   function automatic logic [31:0] sw(input int rs2, input int rs1, input int off);
      return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], OpStore};
   endfunction

   task automatic failRun();
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic checkEq(input string name, input logic [31:0] got,
                          input logic [31:0] expected);
      assert (got === expected)
      else begin
         $display("ERROR %s: expected 0x%08h, got 0x%08h", name, expected, got);
         failRun();
      end
   endtask

   task automatic checkMem(input int addr, input logic [31:0] expected);
      checkEq($sformatf("mem[%0d]", addr), mem[addr], expected);
   endtask

   task automatic stepCycle();
      @(posedge clk);
      #1;
   endtask

   task automatic applyReset();
      resetReq = 1'b1;
      stepCycle();
      resetReq = 1'b0;
      @(posedge rstn);
      stepCycle();
   endtask

   task automatic loadProgram();
      for (int i = 0; i < MemWords; i++) mem[i] = fillWord(i);
      foreach (prog[k]) mem[k] = prog[k];
      prog.delete();
      reqAddrs.delete();
      writeCount = 0;
   endtask

   // pulse start and expect the first fetch at once, then wait for halt
   task automatic runProgram(input logic [31:0] startAddr);
      start = 1'b1;
      stepCycle();
      start = 1'b0;
      checkEq("halted", 32'(halted), 32'h0);
      checkEq("memReqValid", 32'(memReqValid), 32'h1);
      checkEq("memReq.addr", memReq.addr, startAddr);
      while (halted !== 1'b1) stepCycle();
   endtask

   task automatic expectIdle(input int nCycles);
      repeat (nCycles) begin
         stepCycle();
         assert (memReqValid === 1'b0)
         else begin
            $display("a memory request appeared while the core was halted");
            failRun();
         end
      end
   endtask

   task automatic testResetState();
      applyReset();
      checkEq("halted", 32'(halted), 32'h1);
      checkEq("memReqValid", 32'(memReqValid), 32'h0);
      expectIdle(10);
   endtask

   task automatic testImmediateOps();
      applyReset();
      prog = '{lui(1, 20'h12345), sw(1, 0, 100), opImm(3'b000, 2, 0, -7), sw(2, 0, 101),
               opImm(3'b000, 3, 1, 32'h678), sw(3, 0, 102),
               opImm(3'b010, 4, 2, -6), sw(4, 0, 103), opImm(3'b011, 5, 3, -1), sw(5, 0, 104),
               opImm(3'b011, 6, 2, 5), sw(6, 0, 105), opImm(3'b100, 7, 3, 32'h0F0),
               sw(7, 0, 106), opImm(3'b110, 8, 1, 32'h0A5), sw(8, 0, 107),
               opImm(3'b111, 9, 3, -16), sw(9, 0, 108), opImm(3'b001, 10, 3, 4),
               sw(10, 0, 109), opImm(3'b101, 11, 2, 28), sw(11, 0, 110),
               opImm(3'b101, 12, 2, 32'h401), sw(12, 0, 111), HaltWord};
      loadProgram();
      runProgram(32'h0);
      checkMem(100, 32'h1234_5000);
      checkMem(101, 32'hFFFF_FFF9);   // -7
      checkMem(102, 32'h1234_5678);
      checkMem(103, 32'h0000_0001);   // -7 < -6 signed
      checkMem(104, 32'h0000_0001);   // sltiu imm is sign extended
      checkMem(105, 32'h0000_0000);   // -7 is huge unsigned
      checkMem(106, 32'h1234_5688);
      checkMem(107, 32'h1234_50A5);
      checkMem(108, 32'h1234_5670);
      checkMem(109, 32'h2345_6780);
      checkMem(110, 32'h0000_000F);
      checkMem(111, 32'hFFFF_FFFC);   // -7 >>> 1 rounds down to -4
   endtask

   task automatic testRegisterOps(input int delayLimit);
      logic [31:0] expected [8];
      maxDelay = delayLimit;
      applyReset();
      prog = '{lui(1, 20'h87654), opImm(3'b000, 1, 1, 32'h321),
               lui(2, 20'h0F0F0), opImm(3'b000, 2, 2, 32'h0F5)};
      for (int k = 0; k < 8; k++) begin
         prog.push_back(opReg(k == 1 ? 7'b0100000 : 7'b0000000, RegF3[k], 3 + k, 1, 2));
         prog.push_back(sw(3 + k, 0, 120 + k));
      end
      prog.push_back(HaltWord);
      loadProgram();
      runProgram(32'h0);
      // x1 = 8765_4321, x2 = 0F0F_00F5, shift amount 21
      expected = '{32'h9674_4416, 32'h7856_422C, 32'h6420_0000, 32'h0000_0001,
                   32'h0000_0000, 32'h886A_43D4, 32'h8F6F_43F5, 32'h0705_0021};
      for (int k = 0; k < 8; k++) checkMem(120 + k, expected[k]);
      maxDelay = 4;
   endtask

   task automatic testLoadUse();
      applyReset();
      prog = '{lw(1, 0, 200), lw(2, 0, 201), opReg(7'b0, 3'b000, 3, 1, 2), sw(3, 0, 202),
               opImm(3'b000, 4, 0, 190), lw(5, 4, 13), sw(5, 4, 15), sw(3, 4, -2),
               opImm(3'b000, 0, 0, 55), sw(0, 0, 204), lw(0, 0, 200), sw(0, 0, 206),
               HaltWord};
      loadProgram();
      mem[200] = 32'h1357_9BDF;
      mem[201] = 32'h0246_8ACE;
      mem[203] = 32'hCAFE_F00D;
      runProgram(32'h0);
      checkMem(202, 32'h1357_9BDF + 32'h0246_8ACE);
      checkMem(205, 32'hCAFE_F00D);
      checkMem(188, 32'h1357_9BDF + 32'h0246_8ACE);   // negative offset
      checkMem(204, 32'h0);
      checkMem(206, 32'h0);
   endtask

   task automatic testHaltAndIllegal();
      applyReset();
      prog = '{opImm(3'b000, 1, 0, 5), sw(1, 0, 150), HaltWord,
               opImm(3'b000, 2, 0, 9), sw(2, 0, 151), HaltWord};
      loadProgram();
      runProgram(32'h0);
      checkMem(150, 32'd5);
      checkMem(151, fillWord(151));
      checkEq("reqCount", 32'(reqAddrs.size()), 32'd4);
      checkEq("last request addr", reqAddrs[$], 32'd2);   // the halt fetch
      expectIdle(12);
      reqAddrs.delete();
      runProgram(32'd3);
      checkMem(151, 32'd9);
      checkEq("reqCount", 32'(reqAddrs.size()), 32'd4);
      // illegal first instruction with the mul encoding
      applyReset();
      prog = '{opReg(7'b0000001, 3'b000, 3, 1, 2), opImm(3'b000, 1, 0, 42),
               sw(1, 0, 152), HaltWord};
      loadProgram();
      runProgram(32'h0);
      checkEq("writeCount", 32'(writeCount), 32'h0);
      checkEq("reqCount", 32'(reqAddrs.size()), 32'd1);
      checkMem(152, fillWord(152));
      runProgram(32'd1);
      checkMem(152, 32'd42);
      checkEq("writeCount", 32'(writeCount), 32'd1);
   endtask

   // answers each request after 1 to maxDelay cycles
   always begin : memoryModel
      rvPkg::memReqT held;
      int            delay;
      @(posedge clk);
      #1;
      memAck = 1'b0;
      if (memReqValid === 1'b1) begin
         held     = memReq;
         rngState = xorshift(rngState);
         delay    = 1 + int'(rngState % 32'(maxDelay));
         assert (held.addr < MemWords)
         else begin
            $display("memory request outside the 256-word memory");
            failRun();
         end
         repeat (delay - 1) begin
            stepCycle();
            assert (memReqValid === 1'b1 && memReq === held)
            else begin
               $display("memory request changed or dropped before its acknowledge");
               failRun();
            end
         end
         reqAddrs.push_back(held.addr);
         if (held.we) begin
            mem[held.addr[7:0]] = held.wdata;
            writeCount++;
         end else begin
            memRdata = mem[held.addr[7:0]];
         end
         memAck = 1'b1;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MaxCycles) begin
         $display("timeout after %0d cycles, the core did not finish", MaxCycles);
         failRun();
      end
   end

   initial begin
      resetReq   = 1'b0;
      start      = 1'b0;
      memAck     = 1'b0;
      memRdata   = '0;
      rngState   = 32'h9ae3_f384;
      maxDelay   = 4;
      cycles     = 0;
      writeCount = 0;
      @(posedge rstn);
      stepCycle();
      testResetState();
      testImmediateOps();
      testRegisterOps(4);
      testLoadUse();
      testHaltAndIllegal();
      testRegisterOps(8);   // back-pressure with wider ack delays
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
design/rvPkg.sv
design/rvSequencer.sv
design/rvDecoder.sv
design/rvExecute.sv
design/rvRegFile.sv
design/rvCore.sv
dv/tbClock.sv
dv/tbCore.sv
